//--- rtl/axil_pkg.sv
package axil_pkg;

    // response code carried on bresp and rresp
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
    localparam axil_resp_t AXIL_RESP_EXOKAY = 2'b01;
    localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;
    localparam axil_resp_t AXIL_RESP_DECERR = 2'b11;

    // low address bits below the word index
    localparam int AXIL_BYTE_OFFSET = 2;

    // protection field width that this slave ignores
    localparam int AXIL_PROT_WIDTH = 3;

endpackage

//--- rtl/bram_pkg.sv
package bram_pkg;

    // clocks from address to data at the RAM port
    localparam int BRAM_READ_LATENCY = 1;

    // power-up value of every memory bit and of the output register
    localparam logic BRAM_INIT_BIT = 1'b0;

endpackage

//--- rtl/skid_buffer.sv
`timescale 1ns/100ps

module skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     axi_clock,
    input  logic     rst,
    input  payload_t din,
    input  logic     din_valid,
    output logic     din_ready,
    output payload_t dout,
    output logic     dout_valid,
    input  logic     dout_ready
);

    logic     full;
    logic     full_next;
    payload_t hold;

    // occupancy for the next cycle
    always_comb begin
        if (full) begin
            full_next = ~dout_ready;
        end else begin
            full_next = din_valid & din_ready & ~dout_ready;
        end
    end

    always_ff @(posedge axi_clock) begin
        if (rst) begin
            full      <= 1'b0;
            din_ready <= 1'b0;
        end else begin
            full      <= full_next;
            din_ready <= ~full_next;
        end
    end

    // capture only while empty so a held item is never overwritten
    always_ff @(posedge axi_clock) begin
        if (!full) begin
            hold <= din;
        end
    end

    // pass-through when empty
    assign dout       = full ? hold : din;
    assign dout_valid = full | (din_valid & din_ready);

endmodule

//--- rtl/axil_bram_arbiter.sv
`timescale 1ns/100ps

module axil_bram_arbiter
    import axil_pkg::*;
    import bram_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  axi_clock,
    input  logic                  rst,

    // read address from its skid buffer
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic                  raddr_valid,
    output logic                  raddr_ready,

    // write address and data from their skid buffers
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic                  waddr_valid,
    output logic                  waddr_ready,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic                  wdata_valid,
    output logic                  wdata_ready,

    // read response path
    output logic                  rdata_push,
    input  logic                  s_axil_rvalid,
    input  logic                  s_axil_rready,

    // write response channel
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,
    output axil_resp_t            s_axil_bresp,

    // RAM port
    output logic [ADDR_WIDTH-1:0] bram_addr,
    output logic [DATA_WIDTH-1:0] bram_din,
    output logic                  bram_we
);

    logic                         read_stall;
    logic                         write_stall;
    logic                         resp_stall;
    logic                         read_grant;
    logic                         write_grant;
    logic [BRAM_READ_LATENCY-1:0] read_pipe;

    // a held response blocks all new RAM accesses
    assign read_stall  = s_axil_rvalid & ~s_axil_rready;
    assign write_stall = s_axil_bvalid & ~s_axil_bready;
    assign resp_stall  = read_stall | write_stall;

    // reads first, writes need both address and data
    assign read_grant  = raddr_valid & ~resp_stall;
    assign write_grant = waddr_valid & wdata_valid & ~raddr_valid & ~resp_stall;

    assign raddr_ready = read_grant;
    // aw and w pop together
    assign waddr_ready = write_grant;
    assign wdata_ready = write_grant;

    // RAM port drive
    assign bram_addr = write_grant ? waddr : raddr;
    assign bram_din  = wdata;
    assign bram_we   = write_grant;

    // read valid follows the grant by the RAM latency
    always_ff @(posedge axi_clock) begin
        if (rst) begin
            read_pipe <= '0;
        end else begin
            read_pipe <= (read_pipe << 1) | BRAM_READ_LATENCY'(read_grant);
        end
    end

    // the stall rule keeps the read-data buffer empty whenever this fires
    assign rdata_push = read_pipe[BRAM_READ_LATENCY-1];

    // write response
    always_ff @(posedge axi_clock) begin
        if (rst) begin
            s_axil_bvalid <= 1'b0;
        end else if (write_grant) begin
            s_axil_bvalid <= 1'b1;
        end else if (s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
        end
    end

    // no error cases in this slave
    assign s_axil_bresp = AXIL_RESP_OKAY;

endmodule

//--- rtl/bram_sp.sv
`timescale 1ns/100ps

module bram_sp
    import bram_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  axi_clock,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  we,
    output logic [DATA_WIDTH-1:0] dout
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [DATA_WIDTH-1:0] dout_pipe [BRAM_READ_LATENCY];

    // power-up contents
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = {DATA_WIDTH{BRAM_INIT_BIT}};
        end
        for (int j = 0; j < BRAM_READ_LATENCY; j++) begin
            dout_pipe[j] = {DATA_WIDTH{BRAM_INIT_BIT}};
        end
    end

    // read-first: a write cycle returns the old word
    always_ff @(posedge axi_clock) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout_pipe[0] <= mem[addr];
        for (int k = 1; k < BRAM_READ_LATENCY; k++) begin
            dout_pipe[k] <= dout_pipe[k-1];
        end
    end

    assign dout = dout_pipe[BRAM_READ_LATENCY-1];

endmodule

//--- rtl/axil_bram_top.sv
`timescale 1ns/100ps

module axil_bram_top
    import axil_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                                   axi_clock,
    input  logic                                   rst,

    // write address channel
    input  logic [ADDR_WIDTH+AXIL_BYTE_OFFSET-1:0] s_axil_awaddr,
    input  logic [AXIL_PROT_WIDTH-1:0]             s_axil_awprot,
    input  logic                                   s_axil_awvalid,
    output logic                                   s_axil_awready,

    // write data channel, wstrb not used
    input  logic [DATA_WIDTH-1:0]                  s_axil_wdata,
    input  logic [DATA_WIDTH/8-1:0]                s_axil_wstrb,
    input  logic                                   s_axil_wvalid,
    output logic                                   s_axil_wready,

    // write response channel
    output axil_resp_t                             s_axil_bresp,
    output logic                                   s_axil_bvalid,
    input  logic                                   s_axil_bready,

    // read address channel
    input  logic [ADDR_WIDTH+AXIL_BYTE_OFFSET-1:0] s_axil_araddr,
    input  logic [AXIL_PROT_WIDTH-1:0]             s_axil_arprot,
    input  logic                                   s_axil_arvalid,
    output logic                                   s_axil_arready,

    // read data channel
    output logic [DATA_WIDTH-1:0]                  s_axil_rdata,
    output axil_resp_t                             s_axil_rresp,
    output logic                                   s_axil_rvalid,
    input  logic                                   s_axil_rready
);

    typedef logic [ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [DATA_WIDTH-1:0] data_word_t;

    word_addr_t raddr;
    logic       raddr_valid;
    logic       raddr_ready;
    word_addr_t waddr;
    logic       waddr_valid;
    logic       waddr_ready;
    data_word_t wdata;
    logic       wdata_valid;
    logic       wdata_ready;
    logic       rdata_push;
    word_addr_t bram_addr;
    data_word_t bram_din;
    data_word_t bram_dout;
    logic       bram_we;

    assign s_axil_rresp = AXIL_RESP_OKAY;

    // input side, word index taken above the byte offset
    skid_buffer #(.payload_t(word_addr_t)) u_skid_raddr (
        .axi_clock  (axi_clock),
        .rst        (rst),
        .din        (s_axil_araddr[ADDR_WIDTH+AXIL_BYTE_OFFSET-1:AXIL_BYTE_OFFSET]),
        .din_valid  (s_axil_arvalid),
        .din_ready  (s_axil_arready),
        .dout       (raddr),
        .dout_valid (raddr_valid),
        .dout_ready (raddr_ready)
    );

    skid_buffer #(.payload_t(word_addr_t)) u_skid_waddr (
        .axi_clock  (axi_clock),
        .rst        (rst),
        .din        (s_axil_awaddr[ADDR_WIDTH+AXIL_BYTE_OFFSET-1:AXIL_BYTE_OFFSET]),
        .din_valid  (s_axil_awvalid),
        .din_ready  (s_axil_awready),
        .dout       (waddr),
        .dout_valid (waddr_valid),
        .dout_ready (waddr_ready)
    );

    skid_buffer #(.payload_t(data_word_t)) u_skid_wdata (
        .axi_clock  (axi_clock),
        .rst        (rst),
        .din        (s_axil_wdata),
        .din_valid  (s_axil_wvalid),
        .din_ready  (s_axil_wready),
        .dout       (wdata),
        .dout_valid (wdata_valid),
        .dout_ready (wdata_ready)
    );

    axil_bram_arbiter #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_arbiter (
        .axi_clock     (axi_clock),
        .rst           (rst),
        .raddr         (raddr),
        .raddr_valid   (raddr_valid),
        .raddr_ready   (raddr_ready),
        .waddr         (waddr),
        .waddr_valid   (waddr_valid),
        .waddr_ready   (waddr_ready),
        .wdata         (wdata),
        .wdata_valid   (wdata_valid),
        .wdata_ready   (wdata_ready),
        .rdata_push    (rdata_push),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .s_axil_bresp  (s_axil_bresp),
        .bram_addr     (bram_addr),
        .bram_din      (bram_din),
        .bram_we       (bram_we)
    );

    bram_sp #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bram (
        .axi_clock (axi_clock),
        .addr      (bram_addr),
        .din       (bram_din),
        .we        (bram_we),
        .dout      (bram_dout)
    );

    // output side
    // din_ready stays open since the arbiter never pushes into a full buffer
    skid_buffer #(.payload_t(data_word_t)) u_skid_rdata (
        .axi_clock  (axi_clock),
        .rst        (rst),
        .din        (bram_dout),
        .din_valid  (rdata_push),
        .din_ready  (),
        .dout       (s_axil_rdata),
        .dout_valid (s_axil_rvalid),
        .dout_ready (s_axil_rready)
    );

endmodule

//--- tb/axil_bram_assert.sv
`timescale 1ns/100ps

module axil_bram_assert #(
    parameter int DATA_WIDTH = 32
) (
    input logic                  axi_clock,
    input logic                  rst,
    input logic                  s_axil_bvalid,
    input logic                  s_axil_bready,
    input logic [DATA_WIDTH-1:0] s_axil_rdata,
    input logic                  s_axil_rvalid,
    input logic                  s_axil_rready
);

    // responses hold until accepted
    rvalid_held: assert property (@(posedge axi_clock) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else $error("rvalid dropped before rready");

    bvalid_held: assert property (@(posedge axi_clock) disable iff (rst)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else $error("bvalid dropped before bready");

    rdata_stable: assert property (@(posedge axi_clock) disable iff (rst)
        s_axil_rvalid && !s_axil_rready |=> $stable(s_axil_rdata))
    else $error("rdata changed while stalled");

    // nothing left over from before reset
    quiet_after_reset: assert property (@(posedge axi_clock)
        rst |=> !s_axil_rvalid && !s_axil_bvalid)
    else $error("response valid high after reset");

endmodule

bind axil_bram_top axil_bram_assert #(
    .DATA_WIDTH (DATA_WIDTH)
) u_assert (.*);

//--- tb/tb_axil_bram.sv
`timescale 1ns/100ps

module tb_axil_bram
    import axil_pkg::*;
;

    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 10;
    localparam int AW         = ADDR_WIDTH + AXIL_BYTE_OFFSET;
    localparam int TIMEOUT    = 200;
    localparam int NUM_OPS    = 600;

    logic                  axi_clock;
    logic                  rst;
    logic [AW-1:0]         awaddr;
    logic [2:0]            awprot;
    logic                  awvalid;
    logic                  awready;
    logic [DATA_WIDTH-1:0] wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    axil_resp_t            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AW-1:0]         araddr;
    logic [2:0]            arprot;
    logic                  arvalid;
    logic                  arready;
    logic [DATA_WIDTH-1:0] rdata;
    axil_resp_t            rresp;
    logic                  rvalid;
    logic                  rready;

    logic [31:0]           rng_state;
    logic [DATA_WIDTH-1:0] model [2**ADDR_WIDTH];

    axil_bram_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut (
        .axi_clock      (axi_clock),
        .rst            (rst),
        .s_axil_awaddr  (awaddr),
        .s_axil_awprot  (awprot),
        .s_axil_awvalid (awvalid),
        .s_axil_awready (awready),
        .s_axil_wdata   (wdata),
        .s_axil_wstrb   (wstrb),
        .s_axil_wvalid  (wvalid),
        .s_axil_wready  (wready),
        .s_axil_bresp   (bresp),
        .s_axil_bvalid  (bvalid),
        .s_axil_bready  (bready),
        .s_axil_araddr  (araddr),
        .s_axil_arprot  (arprot),
        .s_axil_arvalid (arvalid),
        .s_axil_arready (arready),
        .s_axil_rdata   (rdata),
        .s_axil_rresp   (rresp),
        .s_axil_rvalid  (rvalid),
        .s_axil_rready  (rready)
    );

    always #2 axi_clock = ~axi_clock;

    // LCG, numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        stop_with_error($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                  $time, name, got, expected));
    endtask

    // one read and/or one write, aw and w raised after their own delays
    task automatic run_ops(input logic do_rd, input logic [ADDR_WIDTH-1:0] rd_word,
                           input logic [1:0] rd_lo, input logic do_wr,
                           input logic [ADDR_WIDTH-1:0] wr_word, input logic [1:0] wr_lo,
                           input logic [DATA_WIDTH-1:0] wr_data, input int aw_delay,
                           input int w_delay);
        logic [DATA_WIDTH-1:0] exp_rdata;
        logic ar_done;
        logic aw_done;
        logic w_done;
        logic r_done;
        logic b_done;
        logic ar_fire;
        logic aw_fire;
        logic w_fire;
        logic r_fire;
        logic b_fire;
        int   cyc;
        logic [31:0] rv;
        // read wins arbitration, so it sees the word before this write
        exp_rdata = model[rd_word];
        ar_done = !do_rd;
        r_done  = !do_rd;
        aw_done = !do_wr;
        w_done  = !do_wr;
        b_done  = !do_wr;
        araddr  = {rd_word, rd_lo};
        arvalid = do_rd;
        awaddr  = {wr_word, wr_lo};
        awvalid = do_wr && (aw_delay == 0);
        wdata   = wr_data;
        wvalid  = do_wr && (w_delay == 0);
        cyc     = 0;
        while (!(ar_done && aw_done && w_done && r_done && b_done)) begin
            @(negedge axi_clock);
            ar_fire = arvalid && arready;
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            r_fire  = rvalid && rready;
            b_fire  = bvalid && bready;
            if (r_fire) begin
                assert (!r_done && ar_done)
                else stop_with_error("read response without a pending read address");
                assert (rdata === exp_rdata)
                else report_mismatch("s_axil_rdata", rdata, exp_rdata);
                assert (rresp === AXIL_RESP_OKAY)
                else report_mismatch("s_axil_rresp", 32'(rresp), 32'(AXIL_RESP_OKAY));
                r_done = 1'b1;
            end
            if (b_fire) begin
                assert (!b_done && aw_done && w_done)
                else stop_with_error("write response before aw and w were both accepted");
                assert (bresp === AXIL_RESP_OKAY)
                else report_mismatch("s_axil_bresp", 32'(bresp), 32'(AXIL_RESP_OKAY));
                model[wr_word] = wr_data;
                b_done = 1'b1;
            end
            if (ar_fire) ar_done = 1'b1;
            if (aw_fire) aw_done = 1'b1;
            if (w_fire) w_done = 1'b1;
            cyc++;
            assert (cyc < TIMEOUT)
            else stop_with_error("timeout waiting for read and write responses");
            @(posedge axi_clock);
            #1;
            arvalid = !ar_done;
            awvalid = !aw_done && (cyc >= aw_delay);
            wvalid  = !w_done && (cyc >= w_delay);
            // back-pressure about a quarter of the time
            rv     = next_rand();
            rready = rv[31:30] != 2'b00;
            bready = rv[29:28] != 2'b00;
        end
    endtask

    // no stray responses, slave ready for more
    task automatic check_idle(input int cycles);
        rready = 1'b1;
        bready = 1'b1;
        repeat (cycles) begin
            @(negedge axi_clock);
            assert (!rvalid && !bvalid)
            else stop_with_error("response valid raised with no request pending");
            assert (arready && awready && wready)
            else stop_with_error("ready low while the slave is idle");
        end
        @(posedge axi_clock);
        #1;
    endtask

    initial begin
        logic [31:0] rv;
        logic [31:0] dv;
        int          kind;
        axi_clock = 1'b0;
        rst       = 1'b1;
        rng_state = 32'hc911_b531;
        awaddr    = '0;
        awprot    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hf;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arprot    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
            model[i] = '0;
        end

        repeat (8) @(posedge axi_clock);
        #1;
        rst = 1'b0;
        @(posedge axi_clock);
        @(negedge axi_clock);
        assert (!rvalid && !bvalid)
        else stop_with_error("response valid high after reset");
        assert (arready && awready && wready)
        else stop_with_error("ready not high after reset");
        @(posedge axi_clock);
        #1;
        rready = 1'b1;
        bready = 1'b1;

        // write then read back, and a never written word
        run_ops(1'b0, 10'd0, 2'd0, 1'b1, 10'd5, 2'd0, 32'hdead_beef, 0, 0);
        run_ops(1'b1, 10'd5, 2'd0, 1'b0, 10'd0, 2'd0, 32'h0, 0, 0);
        run_ops(1'b1, 10'd777, 2'd0, 1'b0, 10'd0, 2'd0, 32'h0, 0, 0);
        check_idle(3);

        // same cycle read and write, read gets the old word
        run_ops(1'b1, 10'd5, 2'd0, 1'b1, 10'd5, 2'd0, 32'h1234_5678, 0, 0);
        run_ops(1'b1, 10'd5, 2'd0, 1'b0, 10'd0, 2'd0, 32'h0, 0, 0);

        // low address bits do not select a different word
        run_ops(1'b0, 10'd0, 2'd0, 1'b1, 10'd9, 2'd3, 32'h0bad_cafe, 0, 0);
        run_ops(1'b1, 10'd9, 2'd1, 1'b0, 10'd0, 2'd0, 32'h0, 0, 0);
        run_ops(1'b1, 10'd9, 2'd2, 1'b0, 10'd0, 2'd0, 32'h0, 0, 0);

        // aw and w in different cycles, both orders
        run_ops(1'b0, 10'd0, 2'd0, 1'b1, 10'd12, 2'd0, 32'h0000_0aaa, 3, 0);
        run_ops(1'b0, 10'd0, 2'd0, 1'b1, 10'd13, 2'd0, 32'h0000_0bbb, 0, 4);
        check_idle(3);

        for (int n = 0; n < NUM_OPS; n++) begin
            rv   = next_rand();
            dv   = next_rand();
            kind = int'(rv[1:0]) % 3;
            // small address window so reads hit written words
            run_ops(kind != 1, {4'b0, rv[7:2]}, rv[9:8], kind != 0,
                    rv[31] ? {4'b0, rv[7:2]} : {4'b0, rv[15:10]}, rv[17:16], dv,
                    int'(rv[19:18]), int'(rv[21:20]));
        end
        check_idle(4);

        $display("all tests passed");
        $finish;
    end

endmodule

//--- tb.f
rtl/axil_pkg.sv
rtl/bram_pkg.sv
rtl/skid_buffer.sv
rtl/axil_bram_arbiter.sv
rtl/bram_sp.sv
rtl/axil_bram_top.sv
tb/axil_bram_assert.sv
tb/tb_axil_bram.sv

//--- Makefile
SOURCES := $(wildcard rtl/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_axil_bram: tb.f $(SOURCES)
	verilator --binary --timing --assert -sv -f tb.f --top-module tb_axil_bram \
		-Mdir obj_dir -o Vtb_axil_bram

run: obj_dir/Vtb_axil_bram
	./obj_dir/Vtb_axil_bram

clean:
	rm -rf obj_dir
